/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cpu
FILELIST = verilog.f
OBJDIR   = obj_dir
PASS_MSG = All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

test: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJDIR)

/* bench/cpu_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_assert
(
   input wire        clk,
   input wire        arst_n_i,
   input wire        valid_i,
   input wire        ready_i,
   input wire [31:0] addr_i,
   input wire [31:0] wdata_i,
   input wire        wen_i,
   input wire        ph_f_i,
   input wire        wb_en_i,
   input wire [3:0]  wb_rd_i
);

   logic [31:0] last_fetch_q;
   logic        have_q;
   logic        jumped_q;   // pc written since the last fetch
   logic        fetch_hs;
   int          fail_cnt = 0;   // assertion failures so far

   assign fetch_hs = ph_f_i && valid_i && ready_i;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         last_fetch_q <= 32'd0;
         have_q       <= 1'b0;
         jumped_q     <= 1'b0;
      end
      else if (fetch_hs)
      begin
         last_fetch_q <= addr_i;
         have_q       <= 1'b1;
         jumped_q     <= 1'b0;
      end
      else if (wb_en_i && (wb_rd_i == 4'd15))
         jumped_q <= 1'b1;
   end

   valid_in_reset: assert property (@(posedge clk) !arst_n_i |-> !valid_i)
      else
      begin
         $error("bus valid high during reset");
         fail_cnt++;
      end

   valid_after_reset: assert property (@(posedge clk) $rose(arst_n_i) |-> !valid_i)
      else
      begin
         $error("bus valid high in the first cycle after reset");
         fail_cnt++;
      end

   hold_on_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
      (valid_i && !ready_i) |=> (valid_i && $stable(addr_i) && $stable(wdata_i)
                                 && $stable(wen_i)))
      else
      begin
         $error("bus request changed before its handshake");
         fail_cnt++;
      end

   wen_needs_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
      wen_i |-> valid_i)
      else
      begin
         $error("bus wen high without valid");
         fail_cnt++;
      end

   fetch_sequential: assert property (@(posedge clk) disable iff (!arst_n_i)
      (fetch_hs && have_q && !jumped_q) |-> (addr_i == last_fetch_q + 32'd1))
      else
      begin
         $error("fetch address does not follow the previous one");
         fail_cnt++;
      end

endmodule

`default_nettype wire

/* bench/tb_cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;

   localparam int BASE = 512;     // result slots, r10 holds it
   localparam int TIMEOUT = 20000;

   logic        clk;
   logic        arst_n_i;
   logic        ready;
   logic [31:0] rdata;
   wire         valid;
   wire         wen;
   wire  [31:0] addr;
   wire  [31:0] wdata;

   logic [31:0] mem [1024];
   logic [31:0] exp_addr[$];
   logic [31:0] exp_data[$];
   int          exp_test[$];
   logic [31:0] log_addr[$];
   logic [31:0] log_data[$];
   logic [31:0] fetch_q[$];
   int          pc;
   int          slot;
   int          wait_cnt;
   int          errors;
   int          failed_tests;
   bit          timed_out;
   logic [31:0] jmp_at, jmp_to, call_at, call_to, end_at;

   cpu_top #(.RESET_PC(32'd0)) i_cpu_top
   (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .mbus_valid_o (valid),
      .mbus_ready_i (ready),
      .mbus_addr_o  (addr),
      .mbus_wdata_o (wdata),
      .mbus_wen_o   (wen),
      .mbus_rdata_i (rdata)
   );

   bind cpu_top cpu_assert i_cpu_assert
   (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .valid_i  (mbus_valid_o),
      .ready_i  (mbus_ready_i),
      .addr_i   (mbus_addr_o),
      .wdata_i  (mbus_wdata_o),
      .wen_i    (mbus_wen_o),
      .ph_f_i   (ph_f),
      .wb_en_i  (wb_en),
      .wb_rd_i  (ctrl_bus.rd)
   );

   always #10 clk = ~clk;

   // memory with 0..3 random wait cycles per request
   always @(posedge clk)
   begin
      if (valid && ready)
      begin
         ready    <= 1'b0;
         wait_cnt <= int'($urandom % 4);
         if (wen)
         begin
            mem[addr[9:0]] <= wdata;
            log_addr.push_back(addr);
            log_data.push_back(wdata);
         end
         else if (addr < BASE)
            fetch_q.push_back(addr);   // program lives below the slots
      end
      else if (valid && arst_n_i)
      begin
         if (wait_cnt == 0)
         begin
            ready <= 1'b1;
            rdata <= mem[addr[9:0]];
         end
         else
            wait_cnt <= wait_cnt - 1;
      end
   end

   function automatic logic [31:0] fill_word(int i);
      return 32'hC0DE_0000 | 32'(i);
   endfunction

   function automatic logic [31:0] enc_alu(logic [3:0] cond, bit imm, bit s, logic [3:0] op,
                                           logic [3:0] rd, logic [3:0] ra, logic [7:0] src);
      logic [11:0] low;
      low = imm ? {4'd0, src} : {src[3:0], 8'd0};
      return {cond, imm ? 3'd1 : 3'd0, s, rd, ra, op, low};
   endfunction

   function automatic logic [31:0] enc_mem(logic [3:0] cond, bit ld, logic [3:0] rd,
                                           logic [3:0] ra, logic [15:0] off);
      return {cond, ld ? 3'd7 : 3'd6, 1'b0, rd, ra, off};
   endfunction

   function automatic logic [31:0] enc_call(logic [31:0] target);
      return {4'h0, 3'd2, 1'b0, target[23:0]};
   endfunction

   function automatic logic [31:0] alu_ref(int op, logic [31:0] a, logic [31:0] b);
      case (op)
         0: return a + b;
         1: return a - b;
         2: return a & b;
         3: return a | b;
         4: return a ^ b;
         5: return a << b[4:0];
         6: return a >> b[4:0];
         default: return b;   // mov
      endcase
   endfunction

   // {v, s, z, c} for a - b
   function automatic logic [3:0] cmp_flags(logic [31:0] a, logic [31:0] b);
      logic [31:0] d;
      d = a - b;
      return {(a[31] != b[31]) && (d[31] != a[31]), d[31], d == 32'd0, a >= b};
   endfunction

   function automatic bit cond_ok(int c, logic [3:0] f);
      bit v, s, z, cy;
      {v, s, z, cy} = f;
      case (c)
         1: return z;
         2: return !z;
         3: return cy;
         4: return !cy;
         5: return s;
         6: return !s;
         7: return v;
         8: return !v;
         9: return cy && !z;
         10: return !cy || z;
         11: return s == v;
         12: return s != v;
         13: return !z && (s == v);
         14: return z || (s != v);
         default: return 1'b1;
      endcase
   endfunction

   task automatic put(logic [31:0] w);
      mem[pc] = w;
      pc++;
   endtask

   task automatic expect_store(logic [31:0] a, logic [31:0] d, int t);
      exp_addr.push_back(a);
      exp_data.push_back(d);
      exp_test.push_back(t);
   endtask

   // store rd into the next result slot
   task automatic store_slot(logic [3:0] rd, logic [31:0] d, int t);
      put(enc_mem(4'h0, 0, rd, 4'd10, 16'(slot)));
      expect_store(32'(BASE + slot), d, t);
      slot++;
   endtask

   task automatic build_program();
      logic [31:0] poison;
      logic [31:0] ca, cb;
      logic [3:0]  f;
      poison = enc_mem(4'h0, 0, 4'd9, 4'd10, 16'd388);   // would hit address 900
      pc = 0;
      slot = 0;
      put(enc_alu(4'h0, 1, 0, 4'd7, 4'd10, 4'd0, 8'd2));
      put(enc_alu(4'h0, 1, 0, 4'd5, 4'd10, 4'd10, 8'd8));   // r10 = 512
      put(enc_alu(4'h0, 1, 0, 4'd7, 4'd12, 4'd0, 8'd3));
      put(enc_alu(4'h0, 1, 0, 4'd5, 4'd12, 4'd12, 8'd8));   // r12 = 768
      put(enc_alu(4'h0, 1, 0, 4'd7, 4'd9, 4'd0, 8'h77));
      jmp_at = 32'(pc);
      jmp_to = 32'(pc + 3);
      put(enc_alu(4'h0, 1, 0, 4'd7, 4'd15, 4'd0, jmp_to[7:0]));
      put(poison);
      put(poison);
      put(enc_alu(4'h0, 1, 0, 4'd7, 4'd5, 4'd0, 8'h11));
      store_slot(4'd5, 32'h11, 1);
      call_at = 32'(pc);
      call_to = 32'(pc + 3);
      put(enc_call(call_to));
      put(poison);
      put(poison);
      store_slot(4'd14, call_at + 32'd1, 2);
      // operands 0x1234 and 0x0f0f
      put(enc_alu(4'h0, 1, 0, 4'd7, 4'd1, 4'd0, 8'h12));
      put(enc_alu(4'h0, 1, 0, 4'd5, 4'd1, 4'd1, 8'd8));
      put(enc_alu(4'h0, 1, 0, 4'd3, 4'd1, 4'd1, 8'h34));
      put(enc_alu(4'h0, 1, 0, 4'd7, 4'd2, 4'd0, 8'h0f));
      put(enc_alu(4'h0, 1, 0, 4'd5, 4'd2, 4'd2, 8'd8));
      put(enc_alu(4'h0, 1, 0, 4'd3, 4'd2, 4'd2, 8'h0f));
      for (int op = 0; op < 8; op++)
      begin
         put(enc_alu(4'h0, 0, 0, 4'(op), 4'd4, 4'd1, 8'd2));
         store_slot(4'd4, alu_ref(op, 32'h1234, 32'h0f0f), 3);
         put(enc_alu(4'h0, 1, 0, 4'(op), 4'd4, 4'd1, 8'h5c));
         store_slot(4'd4, alu_ref(op, 32'h1234, 32'h5c), 3);
      end
      put(enc_mem(4'h0, 0, 4'd1, 4'd10, 16'd100));
      expect_store(32'd612, 32'h1234, 4);
      put(enc_mem(4'h0, 0, 4'd2, 4'd12, -16'sd4));
      expect_store(32'd764, 32'h0f0f, 4);
      put(enc_mem(4'h0, 1, 4'd6, 4'd10, 16'd100));
      store_slot(4'd6, 32'h1234, 4);
      put(enc_mem(4'h0, 1, 4'd7, 4'd12, -16'sd4));
      store_slot(4'd7, 32'h0f0f, 4);
      put(enc_mem(4'h0, 1, 4'd8, 4'd12, -16'sd68));   // preloaded word 700
      store_slot(4'd8, fill_word(700), 4);
      for (int p = 0; p < 3; p++)
      begin
         case (p)
            0:
            begin
               ca = 32'd5;
               cb = 32'd5;
               put(enc_alu(4'h0, 1, 0, 4'd7, 4'd1, 4'd0, 8'd5));
            end
            1:
            begin
               ca = 32'h8000_0000;
               cb = 32'd1;
               put(enc_alu(4'h0, 1, 0, 4'd7, 4'd1, 4'd0, 8'd1));
               put(enc_alu(4'h0, 1, 0, 4'd5, 4'd1, 4'd1, 8'd31));
            end
            default:
            begin
               ca = 32'd1;
               cb = 32'd2;
               put(enc_alu(4'h0, 1, 0, 4'd7, 4'd1, 4'd0, 8'd1));
            end
         endcase
         put(enc_alu(4'h0, 1, 0, 4'd7, 4'd2, 4'd0, cb[7:0]));
         put(enc_alu(4'h0, 0, 0, 4'd8, 4'd0, 4'd1, 8'd2));   // cmp r1, r2
         f = cmp_flags(ca, cb);
         for (int c = 0; c < 16; c++)
         begin
            put(enc_alu(4'h0, 1, 0, 4'd7, 4'd5, 4'd0, 8'd0));
            put(enc_alu(4'(c), 1, 0, 4'd7, 4'd5, 4'd0, 8'd1));
            store_slot(4'd5, cond_ok(c, f) ? 32'd1 : 32'd0, 5);
            put(enc_mem(4'(c), 0, 4'd9, 4'd10, 16'd389));
            if (cond_ok(c, f))
               expect_store(32'd901, 32'h77, 5);
         end
      end
      end_at = 32'(pc);
      put(enc_call(end_at));   // park here
   endtask

   function automatic logic [31:0] next_fetch(logic [31:0] src);
      for (int i = 0; i + 1 < fetch_q.size(); i++)
         if (fetch_q[i] == src)
            return fetch_q[i + 1];
      return 32'hffff_ffff;
   endfunction

   task automatic check_test(int t, string name);
      int last;
      int cnt;
      int bad;
      last = 0;
      bad = 0;
      for (int i = 0; i < exp_test.size(); i++)
         if (exp_test[i] == t)
            last = i + 1;
      cnt = 0;
      while (log_addr.size() < last && cnt < TIMEOUT && !timed_out)
      begin
         @(negedge clk);
         cnt++;
      end
      if (log_addr.size() < last)
      begin
         $display("test %0d %s: timed out waiting for stores (%0d of %0d)",
                  t, name, log_addr.size(), last);
         timed_out = 1'b1;
         failed_tests++;
         return;
      end
      for (int i = 0; i < last; i++)
         if (exp_test[i] == t)
         begin
            assert (log_addr[i] == exp_addr[i] && log_data[i] == exp_data[i])
            else
            begin
               $display("Fail %0t: %s store %0d at %h = %h, expected %h = %h", $time, name,
                        i, log_addr[i], log_data[i], exp_addr[i], exp_data[i]);
               bad++;
            end
         end
      if (t == 1)
         assert (next_fetch(jmp_at) == jmp_to)
         else
         begin
            $display("Fail %0t: fetch after mov to pc is %h", $time, next_fetch(jmp_at));
            bad++;
         end
      if (t == 2)
         assert (next_fetch(call_at) == call_to)
         else
         begin
            $display("Fail %0t: fetch after call is %h", $time, next_fetch(call_at));
            bad++;
         end
      errors += bad;
      if (bad != 0)
         failed_tests++;
      $display("test %0d %s: %s", t, name, (bad == 0) ? "ok" : "FAILED");
   endtask

   task automatic check_whole_log();
      int cnt;
      int parked;
      int bad;
      cnt = 0;
      parked = 0;
      bad = 0;
      while (parked < 2 && cnt < TIMEOUT && !timed_out)
      begin
         @(negedge clk);
         cnt++;
         parked = 0;
         foreach (fetch_q[i])
            if (fetch_q[i] == end_at)
               parked++;
      end
      if (parked < 2)
      begin
         $display("test 6 back-pressure: timed out before the program reached its end");
         timed_out = 1'b1;
         failed_tests++;
         return;
      end
      assert (log_addr.size() == exp_addr.size())
      else
      begin
         $display("Fail %0t: %0d stores logged, expected %0d", $time, log_addr.size(),
                  exp_addr.size());
         bad++;
      end
      foreach (log_addr[i])
         assert (log_addr[i] != 32'd900)
         else
         begin
            $display("Fail %0t: store from a skipped instruction reached the bus", $time);
            bad++;
         end
      errors += bad;
      if (bad != 0)
         failed_tests++;
      $display("test 6 back-pressure: %s", (bad == 0) ? "ok" : "FAILED");
   endtask

   initial
   begin
      int assert_fails;
      void'($urandom(9143));
      clk = 1'b0;
      arst_n_i = 1'b0;
      ready = 1'b0;
      rdata = 32'd0;
      wait_cnt = 0;
      errors = 0;
      failed_tests = 0;
      timed_out = 1'b0;
      for (int i = 0; i < 1024; i++)
         mem[i] = fill_word(i);
      build_program();
      repeat (2) @(posedge clk);
      arst_n_i <= 1'b1;
      check_test(1, "jump");
      check_test(2, "call");
      check_test(3, "alu");
      check_test(4, "load/store");
      check_test(5, "conditions");
      check_whole_log();
      assert_fails = i_cpu_top.i_cpu_assert.fail_cnt;
      $display("6 tests, %0d failed, %0d check errors, %0d assertion failures",
               failed_tests, errors, assert_fails);
      if (failed_tests == 0 && !timed_out && assert_fails == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/alu_flags.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_flags
(
   input  wire cpu_isa_pkg::alu_op_e op_i,
   input  wire [31:0]                a_i,
   input  wire [31:0]                b_i,
   input  wire [3:0]                 flags_i,   // current flags, C and V kept
   output logic [31:0]               res_o,
   output logic [3:0]                flags_o
);

   logic [32:0] sum;
   logic [32:0] diff;

   assign sum  = {1'b0, a_i} + {1'b0, b_i};
   assign diff = {1'b0, a_i} - {1'b0, b_i};

   always_comb
   begin
      flags_o = flags_i;
      case (op_i)
         cpu_isa_pkg::ALU_ADD:
         begin
            res_o = sum[31:0];
            flags_o[cpu_arch_pkg::FLAG_C] = sum[32];
            flags_o[cpu_arch_pkg::FLAG_V] = (a_i[31] == b_i[31]) && (sum[31] != a_i[31]);
         end
         cpu_isa_pkg::ALU_SUB, cpu_isa_pkg::ALU_CMP:
         begin
            res_o = diff[31:0];
            flags_o[cpu_arch_pkg::FLAG_C] = !diff[32];   // set when no borrow
            flags_o[cpu_arch_pkg::FLAG_V] = (a_i[31] != b_i[31]) && (diff[31] != a_i[31]);
         end
         cpu_isa_pkg::ALU_AND:
            res_o = a_i & b_i;
         cpu_isa_pkg::ALU_OR:
            res_o = a_i | b_i;
         cpu_isa_pkg::ALU_XOR:
            res_o = a_i ^ b_i;
         cpu_isa_pkg::ALU_SHL:
            res_o = a_i << b_i[4:0];
         cpu_isa_pkg::ALU_SHR:
            res_o = a_i >> b_i[4:0];   // logical
         cpu_isa_pkg::ALU_MOV:
            res_o = b_i;
         default:
            res_o = 32'd0;
      endcase
      flags_o[cpu_arch_pkg::FLAG_Z] = (res_o == 32'd0);
      flags_o[cpu_arch_pkg::FLAG_S] = res_o[31];
   end

endmodule

`default_nettype wire

/* rtl/cpu_arch_pkg.sv */
`default_nettype none

package cpu_arch_pkg;

   typedef enum logic [1:0] {
      PH_FETCH = 2'd0,
      PH_EXEC  = 2'd1,
      PH_MEM   = 2'd2,
      PH_WB    = 2'd3
   } phase_e;

   // bit positions in the flag word
   localparam int unsigned FLAG_C = 0;
   localparam int unsigned FLAG_Z = 1;
   localparam int unsigned FLAG_S = 2;
   localparam int unsigned FLAG_V = 3;

   localparam logic [3:0] REG_LINK = 4'd14;
   localparam logic [3:0] REG_PC   = 4'd15;   // program counter, counts words

endpackage

`default_nettype wire

/* rtl/cpu_ctrl_if.sv */
`timescale 1ns/1ns
`default_nettype none

// decoded controls, valid from EXEC through WB
interface cpu_ctrl_if;
   logic                 ena;       // condition passed
   logic                 is_alu;
   logic                 is_call;
   logic                 is_ld;
   logic                 is_st;
   cpu_isa_pkg::alu_op_e alu_op;
   logic                 flag_en;
   logic                 wb_en;
   logic [3:0]           rd;
   logic [3:0]           ra;
   logic [3:0]           rb;
   logic [31:0]          imm;       // extended per class
   logic                 use_imm;

   modport dec (output ena, is_alu, is_call, is_ld, is_st, alu_op, flag_en,
                output wb_en, rd, ra, rb, imm, use_imm);
   modport dp (input ena, is_alu, is_call, is_ld, is_st, alu_op, flag_en,
               input wb_en, rd, ra, rb, imm, use_imm);
endinterface

`default_nettype wire

/* rtl/cpu_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_datapath
(
   input  wire                  clk,
   input  wire                  arst_n_i,
   input  wire                  ph_f_i,
   input  wire                  ph_e_i,
   input  wire                  ph_m_i,
   input  wire                  ph_w_i,
   input  wire cpu_arch_pkg::phase_e phase_i,
   input  wire                  bus_ready_i,
   input  wire  [31:0]          bus_rdata_i,
   cpu_ctrl_if.dp               ctrl,
   // register file
   input  wire  [31:0]          da_i,
   input  wire  [31:0]          db_i,
   input  wire  [31:0]          dd_i,
   input  wire  [31:0]          pc_i,
   output logic                 inc_pc_o,
   output logic                 link_o,
   output logic                 wb_en_o,
   output logic [31:0]          wb_data_o,
   // alu
   output logic [31:0]          alu_a_o,
   output logic [31:0]          alu_b_o,
   input  wire  [31:0]          alu_res_i,
   input  wire  [3:0]           alu_flags_i,
   output logic [3:0]           flags_o,
   output logic                 mem_req_o,
   output logic                 bus_done_o,
   output logic                 bus_valid_o,
   output logic [31:0]          bus_addr_o,
   output logic                 bus_wen_o,
   output logic [31:0]          bus_wdata_o
);

   logic [31:0] exe_q;         // alu result or ld/st address
   logic [3:0]  exe_flags_q;   // flags from EXEC, committed in WB
   logic [31:0] ld_q;
   logic [3:0]  flags_q;
   logic [31:0] mem_addr;

   assign alu_a_o  = da_i;
   assign alu_b_o  = ctrl.use_imm ? ctrl.imm : db_i;
   assign mem_addr = da_i + ctrl.imm;

   always_ff @(posedge clk)
   begin
      if (ph_e_i)
      begin
         exe_q       <= ctrl.is_alu ? alu_res_i : mem_addr;
         exe_flags_q <= alu_flags_i;
      end
      if (ph_m_i && bus_done_o)
         ld_q <= bus_rdata_i;
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         flags_q <= 4'd0;
      else if (ph_w_i && ctrl.ena && ctrl.flag_en)
         flags_q <= exe_flags_q;
   end

   assign flags_o = flags_q;

   // bus side, fetch at pc or ld/st at the registered address
   assign mem_req_o   = ctrl.ena && (ctrl.is_ld || ctrl.is_st);
   assign bus_valid_o = ph_f_i || (ph_m_i && mem_req_o);
   assign bus_done_o  = bus_valid_o && bus_ready_i;
   assign bus_addr_o  = (phase_i == cpu_arch_pkg::PH_MEM) ? exe_q : pc_i;
   assign bus_wen_o   = ph_m_i && mem_req_o && ctrl.is_st;
   assign bus_wdata_o = dd_i;

   assign inc_pc_o = ph_e_i;   // also for a failed condition
   assign link_o   = ph_e_i && ctrl.ena && ctrl.is_call;
   assign wb_en_o  = ph_w_i && ctrl.ena && ctrl.wb_en;

   always_comb
   begin
      if (ctrl.is_ld)
         wb_data_o = ld_q;
      else if (ctrl.is_call)
         wb_data_o = ctrl.imm;   // target into pc
      else
         wb_data_o = exe_q;
   end

endmodule

`default_nettype wire

/* rtl/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

   // instruction class, bits [27:25]
   typedef enum logic [2:0] {
      CLS_ALU2 = 3'd0,   // rd = ra op rb
      CLS_ALU1 = 3'd1,   // rd = ra op im8
      CLS_CALL = 3'd2,
      CLS_ST_I = 3'd6,
      CLS_LD_I = 3'd7
   } inst_class_e;

   typedef enum logic [3:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_SHL = 4'd5,
      ALU_SHR = 4'd6,
      ALU_MOV = 4'd7,
      ALU_CMP = 4'd8    // sub with flags only
   } alu_op_e;

   typedef enum logic [3:0] {
      COND_AL = 4'h0, COND_EQ = 4'h1, COND_NE = 4'h2, COND_CS = 4'h3,
      COND_CC = 4'h4, COND_MI = 4'h5, COND_PL = 4'h6, COND_VS = 4'h7,
      COND_VC = 4'h8, COND_HI = 4'h9, COND_LS = 4'ha, COND_GE = 4'hb,
      COND_LT = 4'hc, COND_GT = 4'hd, COND_LE = 4'he, COND_NV = 4'hf
   } cond_e;

   typedef struct packed {
      cond_e       cond;
      inst_class_e cls;
      logic        s;      // update flags
      logic [3:0]  rd;
      logic [3:0]  ra;
      alu_op_e     op;
      logic [3:0]  rb;
      logic [7:0]  im8;    // zero-extended
   } instr_reg_t;

   typedef struct packed {
      cond_e       cond;
      inst_class_e cls;
      logic        rsvd;
      logic [3:0]  rd;
      logic [3:0]  ra;
      logic [15:0] im16;   // signed word offset
   } instr_mem_t;

   typedef struct packed {
      cond_e       cond;
      inst_class_e cls;
      logic        rsvd;
      logic [23:0] im24;   // absolute word target
   } instr_call_t;

   typedef union packed {
      instr_reg_t  r;
      instr_mem_t  m;
      instr_call_t c;
   } instr_u;

endpackage

`default_nettype wire

/* rtl/cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_top
#(
   parameter logic [31:0] RESET_PC = 32'h0000_0000
)
(
   input  wire        clk,
   input  wire        arst_n_i,
   output wire        mbus_valid_o,
   input  wire        mbus_ready_i,
   output wire [31:0] mbus_addr_o,
   output wire [31:0] mbus_wdata_o,
   output wire        mbus_wen_o,
   input  wire [31:0] mbus_rdata_i
);

   logic                 ph_f, ph_e, ph_m, ph_w;
   cpu_arch_pkg::phase_e phase;
   logic                 bus_done;
   logic                 mem_req;
   logic [3:0]           flags;
   logic [3:0]           alu_flags;
   logic [31:0]          da, db, dd, pc;
   logic [31:0]          alu_a, alu_b, alu_res;
   logic                 inc_pc, link, wb_en;
   logic [31:0]          wb_data;

   cpu_ctrl_if ctrl_bus ();

   phase_sched i_phase_sched
   (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .bus_done_i (bus_done),
      .mem_req_i  (mem_req),
      .ph_f_o     (ph_f),
      .ph_e_o     (ph_e),
      .ph_m_o     (ph_m),
      .ph_w_o     (ph_w),
      .phase_o    (phase)
   );

   instr_decode i_instr_decode
   (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .load_i   (ph_f & bus_done),   // ir loads on the fetch handshake
      .instr_i  (mbus_rdata_i),
      .flags_i  (flags),
      .ctrl     (ctrl_bus.dec)
   );

   cpu_datapath i_cpu_datapath
   (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .ph_f_i      (ph_f),
      .ph_e_i      (ph_e),
      .ph_m_i      (ph_m),
      .ph_w_i      (ph_w),
      .phase_i     (phase),
      .bus_ready_i (mbus_ready_i),
      .bus_rdata_i (mbus_rdata_i),
      .ctrl        (ctrl_bus.dp),
      .da_i        (da),
      .db_i        (db),
      .dd_i        (dd),
      .pc_i        (pc),
      .inc_pc_o    (inc_pc),
      .link_o      (link),
      .wb_en_o     (wb_en),
      .wb_data_o   (wb_data),
      .alu_a_o     (alu_a),
      .alu_b_o     (alu_b),
      .alu_res_i   (alu_res),
      .alu_flags_i (alu_flags),
      .flags_o     (flags),
      .mem_req_o   (mem_req),
      .bus_done_o  (bus_done),
      .bus_valid_o (mbus_valid_o),
      .bus_addr_o  (mbus_addr_o),
      .bus_wen_o   (mbus_wen_o),
      .bus_wdata_o (mbus_wdata_o)
   );

   alu_flags i_alu_flags
   (
      .op_i    (ctrl_bus.alu_op),
      .a_i     (alu_a),
      .b_i     (alu_b),
      .flags_i (flags),
      .res_o   (alu_res),
      .flags_o (alu_flags)
   );

   reg_file #(.RESET_PC(RESET_PC)) i_reg_file
   (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .ra_i      (ctrl_bus.ra),
      .rb_i      (ctrl_bus.rb),
      .rd_i      (ctrl_bus.rd),
      .inc_pc_i  (inc_pc),
      .link_i    (link),
      .wb_en_i   (wb_en),
      .wb_data_i (wb_data),
      .da_o      (da),
      .db_o      (db),
      .dd_o      (dd),
      .pc_o      (pc)
   );

endmodule

`default_nettype wire

/* rtl/instr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decode
(
   input  wire         clk,
   input  wire         arst_n_i,
   input  wire         load_i,     // fetch handshake
   input  wire  [31:0] instr_i,
   input  wire  [3:0]  flags_i,
   cpu_ctrl_if.dec     ctrl
);

   cpu_isa_pkg::instr_u      ir_q;
   cpu_isa_pkg::inst_class_e cls;
   logic                     is_cmp;
   logic                     fc, fz, fs, fv;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         ir_q <= '0;
      else if (load_i)
         ir_q <= instr_i;
   end

   assign cls = ir_q.r.cls;
   assign fc  = flags_i[cpu_arch_pkg::FLAG_C];
   assign fz  = flags_i[cpu_arch_pkg::FLAG_Z];
   assign fs  = flags_i[cpu_arch_pkg::FLAG_S];
   assign fv  = flags_i[cpu_arch_pkg::FLAG_V];

   // condition test
   always_comb
   begin
      case (ir_q.r.cond)
         cpu_isa_pkg::COND_EQ: ctrl.ena = fz;
         cpu_isa_pkg::COND_NE: ctrl.ena = !fz;
         cpu_isa_pkg::COND_CS: ctrl.ena = fc;
         cpu_isa_pkg::COND_CC: ctrl.ena = !fc;
         cpu_isa_pkg::COND_MI: ctrl.ena = fs;
         cpu_isa_pkg::COND_PL: ctrl.ena = !fs;
         cpu_isa_pkg::COND_VS: ctrl.ena = fv;
         cpu_isa_pkg::COND_VC: ctrl.ena = !fv;
         cpu_isa_pkg::COND_HI: ctrl.ena = fc && !fz;
         cpu_isa_pkg::COND_LS: ctrl.ena = !fc || fz;
         cpu_isa_pkg::COND_GE: ctrl.ena = (fs == fv);
         cpu_isa_pkg::COND_LT: ctrl.ena = (fs != fv);
         cpu_isa_pkg::COND_GT: ctrl.ena = !fz && (fs == fv);
         cpu_isa_pkg::COND_LE: ctrl.ena = fz || (fs != fv);
         default:              ctrl.ena = 1'b1;   // AL and NV
      endcase
   end

   assign ctrl.is_alu  = (cls == cpu_isa_pkg::CLS_ALU2) || (cls == cpu_isa_pkg::CLS_ALU1);
   assign ctrl.is_call = (cls == cpu_isa_pkg::CLS_CALL);
   assign ctrl.is_ld   = (cls == cpu_isa_pkg::CLS_LD_I);
   assign ctrl.is_st   = (cls == cpu_isa_pkg::CLS_ST_I);
   assign is_cmp       = (ir_q.r.op == cpu_isa_pkg::ALU_CMP);

   assign ctrl.alu_op  = ir_q.r.op;
   assign ctrl.wb_en   = (ctrl.is_alu && !is_cmp) || ctrl.is_ld || ctrl.is_call;
   assign ctrl.flag_en = ctrl.is_alu && (is_cmp || ir_q.r.s);
   assign ctrl.use_imm = (cls == cpu_isa_pkg::CLS_ALU1);

   // call writes its target into the pc
   assign ctrl.rd = ctrl.is_call ? cpu_arch_pkg::REG_PC : ir_q.r.rd;
   assign ctrl.ra = ir_q.r.ra;   // same bits in the memory view
   assign ctrl.rb = ir_q.r.rb;

   always_comb
   begin
      case (cls)
         cpu_isa_pkg::CLS_ALU1:
            ctrl.imm = {24'd0, ir_q.r.im8};
         cpu_isa_pkg::CLS_CALL:
            ctrl.imm = {8'd0, ir_q.c.im24};
         cpu_isa_pkg::CLS_ST_I, cpu_isa_pkg::CLS_LD_I:
            ctrl.imm = {{16{ir_q.m.im16[15]}}, ir_q.m.im16};
         default:
            ctrl.imm = 32'd0;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/phase_sched.sv */
`timescale 1ns/1ns
`default_nettype none

module phase_sched
(
   input  wire                  clk,
   input  wire                  arst_n_i,
   input  wire                  bus_done_i,   // handshake this cycle
   input  wire                  mem_req_i,    // ld/st with condition passed
   output logic                 ph_f_o,
   output logic                 ph_e_o,
   output logic                 ph_m_o,
   output logic                 ph_w_o,
   output cpu_arch_pkg::phase_e phase_o
);

   cpu_arch_pkg::phase_e phase_q;
   cpu_arch_pkg::phase_e phase_d;
   logic                 run_q;   // keeps fetch quiet in the cycle after reset

   always_comb
   begin
      phase_d = phase_q;
      case (phase_q)
         cpu_arch_pkg::PH_FETCH:
            if (bus_done_i)
               phase_d = cpu_arch_pkg::PH_EXEC;
         cpu_arch_pkg::PH_EXEC:
            phase_d = cpu_arch_pkg::PH_MEM;
         cpu_arch_pkg::PH_MEM:
            if (!mem_req_i || bus_done_i)
               phase_d = cpu_arch_pkg::PH_WB;
         default:
            phase_d = cpu_arch_pkg::PH_FETCH;   // after WB
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         phase_q <= cpu_arch_pkg::PH_FETCH;
         run_q   <= 1'b0;
      end
      else
      begin
         run_q <= 1'b1;
         if (run_q)
            phase_q <= phase_d;
      end
   end

   assign ph_f_o  = run_q && (phase_q == cpu_arch_pkg::PH_FETCH);
   assign ph_e_o  = (phase_q == cpu_arch_pkg::PH_EXEC);
   assign ph_m_o  = (phase_q == cpu_arch_pkg::PH_MEM);
   assign ph_w_o  = (phase_q == cpu_arch_pkg::PH_WB);
   assign phase_o = phase_q;

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file
#(
   parameter logic [31:0] RESET_PC = 32'h0000_0000
)
(
   input  wire         clk,
   input  wire         arst_n_i,
   input  wire  [3:0]  ra_i,
   input  wire  [3:0]  rb_i,
   input  wire  [3:0]  rd_i,
   input  wire         inc_pc_i,
   input  wire         link_i,      // r14 <= pc + 1
   input  wire         wb_en_i,
   input  wire  [31:0] wb_data_i,
   output logic [31:0] da_o,
   output logic [31:0] db_o,
   output logic [31:0] dd_o,        // store data
   output logic [31:0] pc_o
);

   logic [31:0] rf_q [16];
   logic [31:0] pc_inc;

   assign pc_inc = rf_q[cpu_arch_pkg::REG_PC] + 32'd1;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         for (int i = 0; i < 16; i++)
            rf_q[i] <= 32'd0;
         rf_q[cpu_arch_pkg::REG_PC] <= RESET_PC;
      end
      else
      begin
         if (inc_pc_i)
            rf_q[cpu_arch_pkg::REG_PC] <= pc_inc;
         if (link_i)
            rf_q[cpu_arch_pkg::REG_LINK] <= pc_inc;
         if (wb_en_i)
            rf_q[rd_i] <= wb_data_i;   // a jump beats the increment
      end
   end

   assign da_o = rf_q[ra_i];
   assign db_o = rf_q[rb_i];
   assign dd_o = rf_q[rd_i];
   assign pc_o = rf_q[cpu_arch_pkg::REG_PC];

endmodule

`default_nettype wire

/* verilog.f */
rtl/cpu_isa_pkg.sv
rtl/cpu_arch_pkg.sv
rtl/cpu_ctrl_if.sv
rtl/phase_sched.sv
rtl/instr_decode.sv
rtl/alu_flags.sv
rtl/reg_file.sv
rtl/cpu_datapath.sv
rtl/cpu_top.sv
bench/cpu_assert.sv
bench/tb_cpu.sv
